// File: ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths
`define EX_XLEN      32
`define EX_RADDR_W   5

// jal and the bxxzal forms write here
`define EX_LINK_REG  5'd31

// cp0 cause codes raised in ex
`define EX_EXC_SYS   5'd8
`define EX_EXC_BP    5'd9
`define EX_EXC_RI    5'd10
`define EX_EXC_OV    5'd12
`define EX_EXC_TR    5'd13

// clz/clo count, 0 to 32
`define EX_CNT_W     6
`define EX_CNT_MAX   6'd32

`endif

// File: ex_pkg.sv
`include "ex_consts.svh"

package ex_pkg;

    // instructions handled by the integer execute stage
    typedef enum logic [5:0] {
        OP_RESERVED,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_LUI,
        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
        OP_BEQL, OP_BNEL, OP_BLEZL, OP_BGTZL, OP_BLTZL, OP_BGEZL,
        OP_J, OP_JAL, OP_JR, OP_JALR,
        OP_TGE, OP_TGEU, OP_TLT, OP_TLTU, OP_TEQ, OP_TNE,
        OP_TGEI, OP_TGEIU, OP_TLTI, OP_TLTIU, OP_TEQI, OP_TNEI,
        OP_MULT, OP_MULTU, OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_CLZ, OP_CLO, OP_SYSCALL, OP_BREAK
    } ex_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        ex_op_e                 op;
        logic [`EX_XLEN-1:0]    inst;
        logic [`EX_XLEN-1:0]    pc;
        logic [`EX_XLEN-1:0]    rs_data;
        logic [`EX_XLEN-1:0]    rt_data;
        logic [`EX_XLEN-1:0]    pc_b;
        logic [`EX_XLEN-1:0]    pc_j;
    } ex_in_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]    pc;
        logic [`EX_RADDR_W-1:0] waddr;
        logic                   wen;
        logic [`EX_XLEN-1:0]    result;
    } ex_out_t;

    typedef struct packed {
        logic                   taken;
        logic                   likely_clear;
        logic [`EX_XLEN-1:0]    target;
    } branch_t;

    typedef struct packed {
        logic [`EX_RADDR_W-1:0] addr;
        logic [`EX_XLEN-1:0]    data;
        logic                   ok;
    } fwd_t;

    typedef struct packed {
        logic                   valid;
        logic [4:0]             code;
        logic                   bd;
        logic [`EX_XLEN-1:0]    epc;
    } commit_t;

endpackage

// File: ex_alu.sv
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_alu (
    input  ex_pkg::alu_op_e       alu_op_i,
    input  logic [`EX_XLEN-1:0]   a_i,
    input  logic [`EX_XLEN-1:0]   b_i,
    output logic [`EX_XLEN-1:0]   result_o,
    output logic                  overflow_o
);

    logic [`EX_XLEN-1:0] sum;
    logic [`EX_XLEN-1:0] diff;
    logic [4:0]          shamt;

    assign sum   = a_i + b_i;
    assign diff  = a_i - b_i;
    // shifts take the amount from a, the value from b
    assign shamt = a_i[4:0];

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD:  result_o = sum;
            ex_pkg::ALU_SUB:  result_o = diff;
            ex_pkg::ALU_AND:  result_o = a_i & b_i;
            ex_pkg::ALU_OR:   result_o = a_i | b_i;
            ex_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            ex_pkg::ALU_NOR:  result_o = ~(a_i | b_i);
            ex_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            ex_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, a_i < b_i};
            ex_pkg::ALU_SLL:  result_o = b_i << shamt;
            ex_pkg::ALU_SRL:  result_o = b_i >> shamt;
            ex_pkg::ALU_SRA:  result_o = $signed(b_i) >>> shamt;
            ex_pkg::ALU_LUI:  result_o = {b_i[15:0], 16'h0000};
            default:          result_o = sum;
        endcase
    end

    // signed overflow, operands alike in sign and result not
    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD: begin
                overflow_o = (a_i[`EX_XLEN-1] == b_i[`EX_XLEN-1])
                          && (sum[`EX_XLEN-1] != a_i[`EX_XLEN-1]);
            end
            ex_pkg::ALU_SUB: begin
                overflow_o = (a_i[`EX_XLEN-1] != b_i[`EX_XLEN-1])
                          && (diff[`EX_XLEN-1] != a_i[`EX_XLEN-1]);
            end
            default: overflow_o = 1'b0;
        endcase
    end

    // op decode in ex_stage must only produce the twelve functions
    always_comb begin
        a_alu_op_defined: assert final (alu_op_i <= ex_pkg::ALU_LUI)
            else $error("ex_alu: undefined alu function %0d", alu_op_i);
    end

endmodule

// File: ex_branch_trap.sv
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_branch_trap (
    input  ex_pkg::ex_op_e        op_i,
    input  logic [`EX_XLEN-1:0]   rs_i,
    input  logic [`EX_XLEN-1:0]   rt_i,
    input  logic [`EX_XLEN-1:0]   imm_sx_i,
    input  logic [`EX_XLEN-1:0]   pc_b_i,
    input  logic [`EX_XLEN-1:0]   pc_j_i,
    output ex_pkg::branch_t       branch_o,
    output logic                  trap_o
);

    logic [`EX_XLEN-1:0] cmp_b;
    logic [`EX_XLEN:0]   diff;
    logic                eq;
    logic                lt;
    logic                ltu;
    logic                cond;
    logic                zero_cmp;
    logic                likely;
    logic                is_j;
    logic                is_jr;

    assign zero_cmp = op_i inside {ex_pkg::OP_BLEZ, ex_pkg::OP_BGTZ, ex_pkg::OP_BLTZ,
                                   ex_pkg::OP_BGEZ, ex_pkg::OP_BLTZAL, ex_pkg::OP_BGEZAL,
                                   ex_pkg::OP_BLEZL, ex_pkg::OP_BGTZL, ex_pkg::OP_BLTZL,
                                   ex_pkg::OP_BGEZL};
    assign likely   = op_i inside {ex_pkg::OP_BEQL, ex_pkg::OP_BNEL, ex_pkg::OP_BLEZL,
                                   ex_pkg::OP_BGTZL, ex_pkg::OP_BLTZL, ex_pkg::OP_BGEZL};
    assign is_j     = op_i inside {ex_pkg::OP_J, ex_pkg::OP_JAL};
    assign is_jr    = op_i inside {ex_pkg::OP_JR, ex_pkg::OP_JALR};

    assign cmp_b = (op_i inside {[ex_pkg::OP_TGEI:ex_pkg::OP_TNEI]}) ? imm_sx_i :
                   zero_cmp ? '0 : rt_i;

    // one subtractor, borrow out gives unsigned less
    assign diff = {1'b0, rs_i} - {1'b0, cmp_b};
    assign eq   = diff[`EX_XLEN-1:0] == '0;
    assign ltu  = diff[`EX_XLEN];
    assign lt   = rs_i[`EX_XLEN-1] ^ cmp_b[`EX_XLEN-1] ^ diff[`EX_XLEN];

    always_comb begin
        cond   = 1'b0;
        trap_o = 1'b0;
        case (op_i)
            ex_pkg::OP_BEQ, ex_pkg::OP_BEQL:   cond = eq;
            ex_pkg::OP_BNE, ex_pkg::OP_BNEL:   cond = !eq;
            ex_pkg::OP_BLEZ, ex_pkg::OP_BLEZL: cond = lt || eq;
            ex_pkg::OP_BGTZ, ex_pkg::OP_BGTZL: cond = !lt && !eq;
            ex_pkg::OP_BLTZ, ex_pkg::OP_BLTZL, ex_pkg::OP_BLTZAL: cond = lt;
            ex_pkg::OP_BGEZ, ex_pkg::OP_BGEZL, ex_pkg::OP_BGEZAL: cond = !lt;
            ex_pkg::OP_TGE, ex_pkg::OP_TGEI:   trap_o = !lt;
            ex_pkg::OP_TGEU, ex_pkg::OP_TGEIU: trap_o = !ltu;
            ex_pkg::OP_TLT, ex_pkg::OP_TLTI:   trap_o = lt;
            ex_pkg::OP_TLTU, ex_pkg::OP_TLTIU: trap_o = ltu;
            ex_pkg::OP_TEQ, ex_pkg::OP_TEQI:   trap_o = eq;
            ex_pkg::OP_TNE, ex_pkg::OP_TNEI:   trap_o = !eq;
            default: ;
        endcase
    end

    assign branch_o.taken        = is_j || is_jr || cond;
    // not-taken likely branch kills its delay slot
    assign branch_o.likely_clear = likely && !cond;
    assign branch_o.target       = is_jr ? rs_i : is_j ? pc_j_i : pc_b_i;

endmodule

// File: ex_hilo.sv
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_hilo (
    input  logic                  clk,
    input  logic                  resetn,
    input  ex_pkg::ex_op_e        op_i,
    input  logic                  wr_i,
    input  logic [`EX_XLEN-1:0]   rs_i,
    input  logic [`EX_XLEN-1:0]   rt_i,
    output logic [`EX_XLEN-1:0]   hi_o,
    output logic [`EX_XLEN-1:0]   lo_o
);

    logic [2*`EX_XLEN-1:0] prod_s;
    logic [2*`EX_XLEN-1:0] prod_u;

    // single-cycle products
    assign prod_s = $signed(rs_i) * $signed(rt_i);
    assign prod_u = rs_i * rt_i;

    always_ff @(posedge clk) begin
        if (wr_i) begin
            case (op_i)
                ex_pkg::OP_MULT:  {hi_o, lo_o} <= prod_s;
                ex_pkg::OP_MULTU: {hi_o, lo_o} <= prod_u;
                ex_pkg::OP_MTHI:  hi_o <= rs_i;
                ex_pkg::OP_MTLO:  lo_o <= rs_i;
                default: ;
            endcase
        end
    end

    // the stage strobes only for the four hi/lo writers
    a_wr_op: assert property (@(posedge clk) disable iff (!resetn)
        wr_i |-> op_i inside {ex_pkg::OP_MULT, ex_pkg::OP_MULTU,
                              ex_pkg::OP_MTHI, ex_pkg::OP_MTLO})
        else $error("ex_hilo: write strobe with op %s", op_i.name());

endmodule

// File: ex_lead_count.sv
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_lead_count (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  start_i,
    input  logic                  count_ones_i,
    input  logic [`EX_XLEN-1:0]   operand_i,
    output logic                  busy_o,
    output logic                  count_done_o,
    output logic [`EX_CNT_W-1:0]  count_o
);

    logic [`EX_XLEN-1:0] shift_q;

    // leading bit run ends at a zero or after the full word
    assign count_done_o = busy_o && (!shift_q[`EX_XLEN-1] || count_o == `EX_CNT_MAX);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_o  <= 1'b0;
            count_o <= '0;
        end else if (!busy_o) begin
            if (start_i) begin
                busy_o  <= 1'b1;
                count_o <= '0;
            end
        end else if (!start_i || count_done_o) begin
            // count stays put for the result mux
            busy_o <= 1'b0;
        end else begin
            count_o <= count_o + 1'b1;
        end
    end

    // zeros are inverted so both forms count ones
    always_ff @(posedge clk) begin
        if (!busy_o && start_i) begin
            shift_q <= count_ones_i ? operand_i : ~operand_i;
        end else if (busy_o && !count_done_o) begin
            shift_q <= shift_q << 1;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!resetn)
        count_o <= `EX_CNT_MAX)
        else $error("ex_lead_count: count %0d past word width", count_o);

endmodule

// File: ex_stage.sv
`timescale 1ns/100ps
`include "ex_consts.svh"

module ex_stage (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid_i,
    input  ex_pkg::ex_in_t    ex_in_i,
    output logic              done_o,
    input  logic              ready_i,
    input  logic              branch_ready_i,
    output ex_pkg::branch_t   branch_o,
    output ex_pkg::fwd_t      fwd_o,
    output logic              valid_o,
    output ex_pkg::ex_out_t   ex_out_o,
    output ex_pkg::commit_t   commit_o
);

    ex_pkg::ex_op_e           op;
    ex_pkg::alu_op_e          alu_op;
    ex_pkg::branch_t          bt;
    logic [`EX_XLEN-1:0]      inst;
    logic [`EX_XLEN-1:0]      imm_sx;
    logic [`EX_XLEN-1:0]      imm_zx;
    logic [`EX_XLEN-1:0]      alu_a;
    logic [`EX_XLEN-1:0]      alu_b;
    logic [`EX_XLEN-1:0]      alu_result;
    logic [`EX_XLEN-1:0]      hi;
    logic [`EX_XLEN-1:0]      lo;
    logic [`EX_XLEN-1:0]      result;
    logic [`EX_CNT_W-1:0]     lead_cnt;
    logic [`EX_RADDR_W-1:0]   waddr;
    logic [4:0]               exc_code;
    logic                     alu_ov, trap, cnt_busy, cnt_done;
    logic                     done_q, valid, unit_done, prev_br;
    logic                     b_imm, a_sa, wr_ra, wr_rd, wen, do_link;
    logic                     is_br, is_cnt, hilo_op, ov_exc, exc;

    assign op     = ex_in_i.op;
    assign inst   = ex_in_i.inst;
    assign imm_sx = {{16{inst[15]}}, inst[15:0]};
    assign imm_zx = {16'h0000, inst[15:0]};
    // done_q blocks a second start while output is stalled
    assign valid  = valid_i && !done_q;

    always_comb begin
        case (op)
            ex_pkg::OP_SUB, ex_pkg::OP_SUBU:   alu_op = ex_pkg::ALU_SUB;
            ex_pkg::OP_AND, ex_pkg::OP_ANDI:   alu_op = ex_pkg::ALU_AND;
            ex_pkg::OP_OR, ex_pkg::OP_ORI:     alu_op = ex_pkg::ALU_OR;
            ex_pkg::OP_XOR:                    alu_op = ex_pkg::ALU_XOR;
            ex_pkg::OP_NOR:                    alu_op = ex_pkg::ALU_NOR;
            ex_pkg::OP_SLT, ex_pkg::OP_SLTI:   alu_op = ex_pkg::ALU_SLT;
            ex_pkg::OP_SLTU, ex_pkg::OP_SLTIU: alu_op = ex_pkg::ALU_SLTU;
            ex_pkg::OP_SLL, ex_pkg::OP_SLLV:   alu_op = ex_pkg::ALU_SLL;
            ex_pkg::OP_SRL, ex_pkg::OP_SRLV:   alu_op = ex_pkg::ALU_SRL;
            ex_pkg::OP_SRA, ex_pkg::OP_SRAV:   alu_op = ex_pkg::ALU_SRA;
            ex_pkg::OP_LUI:                    alu_op = ex_pkg::ALU_LUI;
            default:                           alu_op = ex_pkg::ALU_ADD;
        endcase
    end

    // operand and destination classes, immediates write rt
    assign b_imm   = op inside {[ex_pkg::OP_ADDI:ex_pkg::OP_LUI]};
    assign a_sa    = op inside {ex_pkg::OP_SLL, ex_pkg::OP_SRL, ex_pkg::OP_SRA};
    assign wr_ra   = op inside {ex_pkg::OP_JAL, ex_pkg::OP_BLTZAL, ex_pkg::OP_BGEZAL};
    assign do_link = wr_ra || op == ex_pkg::OP_JALR;
    assign is_cnt  = op inside {ex_pkg::OP_CLZ, ex_pkg::OP_CLO};
    assign wr_rd   = op inside {[ex_pkg::OP_ADD:ex_pkg::OP_SRAV], ex_pkg::OP_JALR,
                                ex_pkg::OP_MFHI, ex_pkg::OP_MFLO} || is_cnt;
    assign is_br   = op inside {[ex_pkg::OP_BEQ:ex_pkg::OP_JALR]};
    assign hilo_op = op inside {ex_pkg::OP_MULT, ex_pkg::OP_MULTU,
                                ex_pkg::OP_MTHI, ex_pkg::OP_MTLO};
    assign wen     = b_imm || wr_rd || wr_ra;
    assign waddr   = wr_ra ? `EX_LINK_REG : b_imm ? inst[20:16] : wr_rd ? inst[15:11] : '0;

    assign alu_a = a_sa ? {{(`EX_XLEN-5){1'b0}}, inst[10:6]} : ex_in_i.rs_data;
    assign alu_b = !b_imm ? ex_in_i.rt_data :
                   (op inside {ex_pkg::OP_ANDI, ex_pkg::OP_ORI}) ? imm_zx : imm_sx;

    ex_alu u_alu (
        .alu_op_i   (alu_op),
        .a_i        (alu_a),
        .b_i        (alu_b),
        .result_o   (alu_result),
        .overflow_o (alu_ov)
    );

    ex_branch_trap u_branch_trap (
        .op_i       (op),
        .rs_i       (ex_in_i.rs_data),
        .rt_i       (ex_in_i.rt_data),
        .imm_sx_i   (imm_sx),
        .pc_b_i     (ex_in_i.pc_b),
        .pc_j_i     (ex_in_i.pc_j),
        .branch_o   (bt),
        .trap_o     (trap)
    );

    ex_hilo u_hilo (
        .clk        (clk),
        .resetn     (resetn),
        .op_i       (op),
        .wr_i       (valid && hilo_op),
        .rs_i       (ex_in_i.rs_data),
        .rt_i       (ex_in_i.rt_data),
        .hi_o       (hi),
        .lo_o       (lo)
    );

    ex_lead_count u_lead_count (
        .clk          (clk),
        .resetn       (resetn),
        .start_i      (valid && is_cnt),
        .count_ones_i (op == ex_pkg::OP_CLO),
        .operand_i    (ex_in_i.rs_data),
        .busy_o       (cnt_busy),
        .count_done_o (cnt_done),
        .count_o      (lead_cnt)
    );

    always_comb begin
        if (do_link) result = ex_in_i.pc + 32'd8;
        else if (op == ex_pkg::OP_MFHI) result = hi;
        else if (op == ex_pkg::OP_MFLO) result = lo;
        else if (is_cnt) result = {{(`EX_XLEN-`EX_CNT_W){1'b0}}, lead_cnt};
        else result = alu_result;
    end

    // exceptions, highest priority first
    assign ov_exc = alu_ov && op inside {ex_pkg::OP_ADD, ex_pkg::OP_SUB, ex_pkg::OP_ADDI};
    assign exc    = op inside {ex_pkg::OP_RESERVED, ex_pkg::OP_SYSCALL, ex_pkg::OP_BREAK}
                 || trap || ov_exc;
    assign exc_code = (op == ex_pkg::OP_RESERVED) ? `EX_EXC_RI  :
                      (op == ex_pkg::OP_SYSCALL)  ? `EX_EXC_SYS :
                      (op == ex_pkg::OP_BREAK)    ? `EX_EXC_BP  :
                      trap                        ? `EX_EXC_TR  : `EX_EXC_OV;

    // branches wait for fetch, clz/clo for the counter
    assign unit_done = is_br ? branch_ready_i : is_cnt ? (cnt_busy && cnt_done) : 1'b1;
    assign done_o    = done_q || (valid && unit_done);

    always_ff @(posedge clk) begin
        if (!resetn) done_q <= 1'b0;
        else if (ready_i) done_q <= 1'b0;
        else if (valid_i && done_o) done_q <= 1'b1;
    end

    // was the last accepted instruction a branch or jump
    always_ff @(posedge clk) begin
        if (!resetn) prev_br <= 1'b0;
        else if (valid_i && done_o && ready_i) prev_br <= is_br;
    end

    assign commit_o.valid = valid && exc;
    assign commit_o.code  = exc_code;
    assign commit_o.bd    = prev_br;
    assign commit_o.epc   = prev_br ? ex_in_i.pc - 32'd4 : ex_in_i.pc;

    assign branch_o.taken        = valid && branch_ready_i && bt.taken;
    assign branch_o.likely_clear = valid && branch_ready_i && bt.likely_clear;
    assign branch_o.target       = bt.target;

    assign fwd_o.addr = (valid_i && wen) ? waddr : '0;
    assign fwd_o.data = result;
    assign fwd_o.ok   = valid_i && done_o && wen && !exc;

    always_ff @(posedge clk) begin
        if (!resetn) valid_o <= 1'b0;
        else if (ready_i) valid_o <= valid_i && done_o && !exc;
    end

    always_ff @(posedge clk) begin
        if (ready_i) begin
            ex_out_o.pc     <= ex_in_i.pc;
            ex_out_o.waddr  <= waddr;
            ex_out_o.wen    <= wen;
            ex_out_o.result <= result;
        end
    end

endmodule

// File: tb_ex_vectors.svh
// columns: op, rs, rt, inst, pc, pc_b, pc_j, result, waddr, code,
// {taken, likely_clear}, target, bd
typedef struct packed {
    ex_pkg::ex_op_e          op;
    logic [`EX_XLEN-1:0]     rs;
    logic [`EX_XLEN-1:0]     rt;
    logic [`EX_XLEN-1:0]     inst;
    logic [`EX_XLEN-1:0]     pc;
    logic [`EX_XLEN-1:0]     pc_b;
    logic [`EX_XLEN-1:0]     pc_j;
    logic [`EX_XLEN-1:0]     res;
    logic [`EX_RADDR_W-1:0]  waddr;
    logic [4:0]              code;
    logic [1:0]              br;
    logic [`EX_XLEN-1:0]     tgt;
    logic                    bd;
} vec_t;

localparam int NUM_VEC = 37;

// code 0 means no exception, waddr 0 means no register write
vec_t vectors [NUM_VEC] = '{
    '{ex_pkg::OP_ADDU, 5, 7, 'h21800, 'h100, 0, 0, 'hC, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_SUBU, 5, 7, 'h21800, 'h104, 0, 0, 'hFFFFFFFE, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_NOR, 'hF0F00000, 'hFF, 'h21800, 'h108, 0, 0, 'h0F0FFF00, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_SLT, 'hFFFFFFFF, 1, 'h21800, 'h10C, 0, 0, 1, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_SLTU, 'hFFFFFFFF, 1, 'h21800, 'h110, 0, 0, 0, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_SRA, 0, 'h80000000, 'h21900, 'h114, 0, 0, 'hF8000000, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_SLLV, 8, 1, 'h21800, 'h118, 0, 0, 'h100, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_ANDI, 'hFFFFFFFF, 0, 'h28001, 'h11C, 0, 0, 'h8001, 2, 0, 0, 0, 0},
    '{ex_pkg::OP_ADDIU, 'h10, 0, 'h2FFFF, 'h120, 0, 0, 'hF, 2, 0, 0, 0, 0},
    '{ex_pkg::OP_SLTI, 'hFFFFFFFE, 0, 'h2FFFF, 'h124, 0, 0, 1, 2, 0, 0, 0, 0},
    '{ex_pkg::OP_LUI, 0, 0, 'h21234, 'h128, 0, 0, 'h12340000, 2, 0, 0, 0, 0},
    '{ex_pkg::OP_ADD, 'h7FFFFFFF, 1, 'h21800, 'h12C, 0, 0, 0, 0, `EX_EXC_OV, 0, 0, 0},
    '{ex_pkg::OP_TEQ, 5, 5, 'h21800, 'h130, 0, 0, 0, 0, `EX_EXC_TR, 0, 0, 0},
    '{ex_pkg::OP_TLTIU, 1, 0, 'h20002, 'h134, 0, 0, 0, 0, `EX_EXC_TR, 0, 0, 0},
    '{ex_pkg::OP_SYSCALL, 0, 0, 0, 'h138, 0, 0, 0, 0, `EX_EXC_SYS, 0, 0, 0},
    // taken branch, then faults in the delay slot
    '{ex_pkg::OP_BEQ, 3, 3, 'h21800, 'h13C, 'h2000, 0, 0, 0, 0, 2'b10, 'h2000, 0},
    '{ex_pkg::OP_RESERVED, 0, 0, 0, 'h140, 0, 0, 0, 0, `EX_EXC_RI, 0, 0, 1},
    '{ex_pkg::OP_JR, 'h3000, 0, 'h21800, 'h144, 0, 0, 0, 0, 0, 2'b10, 'h3000, 0},
    '{ex_pkg::OP_BREAK, 0, 0, 0, 'h148, 0, 0, 0, 0, `EX_EXC_BP, 0, 0, 1},
    '{ex_pkg::OP_JAL, 0, 0, 0, 'h14C, 0, 'h4000, 'h154, 31, 0, 2'b10, 'h4000, 0},
    '{ex_pkg::OP_BGEZAL, 0, 0, 'h21800, 'h150, 'h2040, 0, 'h158, 31, 0, 2'b10, 'h2040, 0},
    '{ex_pkg::OP_BNEL, 1, 1, 'h21800, 'h154, 'h2080, 0, 0, 0, 0, 2'b01, 0, 0},
    '{ex_pkg::OP_TNE, 1, 2, 'h21800, 'h158, 0, 0, 0, 0, `EX_EXC_TR, 0, 0, 1},
    // leading counts, latency follows the count
    '{ex_pkg::OP_CLZ, 0, 0, 'h21800, 'h15C, 0, 0, 32, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_CLZ, 'h10000, 0, 'h21800, 'h160, 0, 0, 15, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_CLO, 'hFFFFFFFF, 0, 'h21800, 'h164, 0, 0, 32, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_CLO, 'h7FFFFFFF, 0, 'h21800, 'h168, 0, 0, 0, 3, 0, 0, 0, 0},
    // -2 * 3 signed, then unsigned
    '{ex_pkg::OP_MULT, 'hFFFFFFFE, 3, 'h21800, 'h16C, 0, 0, 0, 0, 0, 0, 0, 0},
    '{ex_pkg::OP_MFHI, 0, 0, 'h21800, 'h170, 0, 0, 'hFFFFFFFF, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_MFLO, 0, 0, 'h21800, 'h174, 0, 0, 'hFFFFFFFA, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_MULTU, 'hFFFFFFFE, 3, 'h21800, 'h178, 0, 0, 0, 0, 0, 0, 0, 0},
    '{ex_pkg::OP_MFHI, 0, 0, 'h21800, 'h17C, 0, 0, 2, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_MFLO, 0, 0, 'h21800, 'h180, 0, 0, 'hFFFFFFFA, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_MTHI, 'h0BAD0002, 0, 'h21800, 'h184, 0, 0, 0, 0, 0, 0, 0, 0},
    '{ex_pkg::OP_MFHI, 0, 0, 'h21800, 'h188, 0, 0, 'h0BAD0002, 3, 0, 0, 0, 0},
    '{ex_pkg::OP_MTLO, 'hCAFE0001, 0, 'h21800, 'h18C, 0, 0, 0, 0, 0, 0, 0, 0},
    '{ex_pkg::OP_MFLO, 0, 0, 'h21800, 'h190, 0, 0, 'hCAFE0001, 3, 0, 0, 0, 0}
};

// File: tb_ex_stage.sv
`timescale 1ns/100ps
`include "ex_consts.svh"

module tb_ex_stage;

    logic             clk;
    logic             resetn;
    logic             valid_i;
    ex_pkg::ex_in_t   ex_in_i;
    logic             done_o;
    logic             ready_i;
    logic             branch_ready_i;
    ex_pkg::branch_t  branch_o;
    ex_pkg::fwd_t     fwd_o;
    logic             valid_o;
    ex_pkg::ex_out_t  ex_out_o;
    ex_pkg::commit_t  commit_o;

    `include "tb_ex_vectors.svh"

    localparam int MAX_CYCLES = NUM_VEC * 50;

    integer seed = 32'he9d9;
    int     cycles = 0;
    int     outputs_seen = 0;
    int     outputs_expected = 0;

    ex_stage UUT (
        .clk            (clk),
        .resetn         (resetn),
        .valid_i        (valid_i),
        .ex_in_i        (ex_in_i),
        .done_o         (done_o),
        .ready_i        (ready_i),
        .branch_ready_i (branch_ready_i),
        .branch_o       (branch_o),
        .fwd_o          (fwd_o),
        .valid_o        (valid_o),
        .ex_out_o       (ex_out_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the stage stopped accepting instructions");
            $display("Simulation FAILED");
            $fatal(1, "cycle limit of %0d reached", MAX_CYCLES);
        end
    end

    // each output taken downstream once
    always @(negedge clk) begin
        if (resetn && valid_o && ready_i) outputs_seen++;
    end

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic run_vector(input int idx);
        vec_t         v;
        string        name;
        logic         accepted;
        logic         exc_seen;
        logic         taken_seen;
        logic         clear_seen;
        logic [4:0]   code_seen;
        logic         bd_seen;
        logic [31:0]  epc_seen;
        logic [31:0]  tgt_seen;
        ex_pkg::fwd_t fwd_seen;
        v = vectors[idx];
        name = $sformatf("vector %0d %s", idx, v.op.name());
        accepted = 1'b0;
        exc_seen = 1'b0;
        taken_seen = 1'b0;
        clear_seen = 1'b0;
        code_seen = '0;
        bd_seen = 1'b0;
        epc_seen = '0;
        tgt_seen = '0;
        fwd_seen = '0;
        valid_i <= 1'b1;
        ex_in_i <= '{v.op, v.inst, v.pc, v.rs, v.rt, v.pc_b, v.pc_j};
        ready_i <= random_bit();
        branch_ready_i <= random_bit();
        while (!accepted) begin
            @(negedge clk);
            if (commit_o.valid) begin
                exc_seen = 1'b1;
                code_seen = commit_o.code;
                bd_seen = commit_o.bd;
                epc_seen = commit_o.epc;
            end
            if (branch_o.taken) begin
                taken_seen = 1'b1;
                tgt_seen = branch_o.target;
            end
            if (branch_o.likely_clear) clear_seen = 1'b1;
            // last sample is the accepting cycle
            fwd_seen = fwd_o;
            accepted = done_o && ready_i;
            @(posedge clk);
            if (accepted) begin
                valid_i <= 1'b0;
                ready_i <= 1'b1;
            end else begin
                ready_i <= random_bit();
                branch_ready_i <= random_bit();
            end
        end
        // output register loaded at the accepting edge
        @(negedge clk);
        check_value({name, " exception"}, v.code != 0, exc_seen);
        check_value({name, " valid_o"}, v.code == 0, valid_o);
        check_value({name, " branch"}, v.br, {taken_seen, clear_seen});
        if (v.br[1]) check_value({name, " target"}, v.tgt, tgt_seen);
        check_value({name, " fwd ok"}, v.code == 0 && v.waddr != 0, fwd_seen.ok);
        if (v.code != 0) begin
            check_value({name, " code"}, v.code, code_seen);
            check_value({name, " bd"}, v.bd, bd_seen);
            check_value({name, " epc"}, v.bd ? v.pc - 32'd4 : v.pc, epc_seen);
        end else begin
            check_value({name, " pc"}, v.pc, ex_out_o.pc);
            check_value({name, " wen"}, v.waddr != 0, ex_out_o.wen);
            check_value({name, " waddr"}, v.waddr, ex_out_o.waddr);
            if (v.waddr != 0) begin
                check_value({name, " result"}, v.res, ex_out_o.result);
                check_value({name, " fwd addr"}, v.waddr, fwd_seen.addr);
                check_value({name, " fwd data"}, v.res, fwd_seen.data);
            end
        end
        @(posedge clk);
    endtask

    initial begin
        resetn = 1'b0;
        valid_i = 1'b0;
        ex_in_i = '0;
        ready_i = 1'b0;
        branch_ready_i = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (vectors[i].code == 0) outputs_expected++;
            run_vector(i);
        end
        check_value("output count", outputs_expected, outputs_seen);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_branch_trap.sv
ex_hilo.sv
ex_lead_count.sv
ex_stage.sv
tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - .
    files:
      - ex_pkg.sv
      - ex_alu.sv
      - ex_branch_trap.sv
      - ex_hilo.sv
      - ex_lead_count.sv
      - ex_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ex_stage.sv
